// ==== luma_cost_pkg.sv ====
/*
 * Shared widths, APB register map, qp limits and the
 * H.264 forward quantizer multiplier table
 */
`default_nettype none

package luma_cost_pkg;

    // ------------------------------------------------------------------
    // Block and sample widths
    // ------------------------------------------------------------------
    localparam int PIX_W   = 8;
    localparam int RES_W   = 9;
    localparam int COEF_W  = 16;
    localparam int LEVEL_W = 16;
    localparam int COST_W  = 32;
    localparam int N_COEF  = 16;

    // ------------------------------------------------------------------
    // Quantization
    // ------------------------------------------------------------------
    localparam int QP_W = 6;
    localparam logic [QP_W-1:0] QP_MAX   = 6'd51;
    localparam logic [QP_W-1:0] QP_RESET = 6'd26;
    // Shift is QBITS_BASE + qp/6
    localparam int QBITS_BASE = 15;

    // Rows by qp%6, columns by position class (even/even, odd/odd, mixed)
    localparam logic [0:5][0:2][15:0] QUANT_MF = '{
        '{16'd13107, 16'd5243, 16'd8066},
        '{16'd11916, 16'd4660, 16'd7490},
        '{16'd10082, 16'd4194, 16'd6554},
        '{16'd9362,  16'd3647, 16'd5825},
        '{16'd8192,  16'd3355, 16'd5243},
        '{16'd7282,  16'd2893, 16'd4559}
    };

    // ------------------------------------------------------------------
    // APB register map
    // ------------------------------------------------------------------
    localparam int PADDR_W = 4;
    localparam int PDATA_W = 32;
    localparam int CNT_W   = 32;
    localparam logic [PADDR_W-1:0] ADDR_QP       = 4'h0;
    localparam logic [PADDR_W-1:0] ADDR_BLK_CNT  = 4'h4;
    localparam logic [PADDR_W-1:0] ADDR_COST_TOT = 4'h8;
    localparam logic [PADDR_W-1:0] ADDR_CLEAR    = 4'hC;

endpackage

`default_nettype wire

// ==== residual_stage.sv ====
/*
 * Residual stage: original minus prediction for all sixteen
 * samples, registered with a one-cycle valid
 */
`timescale 1ns/100ps
`default_nettype none

module residual_stage (
    input  logic clk,
    input  logic rst_n,
    input  logic in_valid,
    input  logic [luma_cost_pkg::N_COEF*luma_cost_pkg::PIX_W-1:0] orig,
    input  logic [luma_cost_pkg::N_COEF*luma_cost_pkg::PIX_W-1:0] pred,
    output logic res_valid,
    output logic [luma_cost_pkg::N_COEF*luma_cost_pkg::RES_W-1:0] res
);
    import luma_cost_pkg::*;

    // Signed differences, range -255..255
    logic signed [RES_W-1:0] diff [N_COEF];

    always_comb begin
        for (int i = 0; i < N_COEF; i++) begin
            // Zero-extend both pixels before subtracting
            diff[i] = $signed({1'b0, orig[i*PIX_W +: PIX_W]})
                    - $signed({1'b0, pred[i*PIX_W +: PIX_W]});
        end
    end

    // Valid pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
        end
    end

    // Residual payload, loaded only with a block
    always_ff @(posedge clk) begin
        if (in_valid) begin
            for (int i = 0; i < N_COEF; i++) begin
                res[i*RES_W +: RES_W] <= diff[i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== fwd_transform_4x4.sv ====
/*
 * 4x4 integer core transform C.X.Ct in two registered passes,
 * rows in the first cycle and columns in the second
 */
`timescale 1ns/100ps
`default_nettype none

module fwd_transform_4x4 (
    input  logic clk,
    input  logic rst_n,
    input  logic res_valid,
    input  logic [luma_cost_pkg::N_COEF*luma_cost_pkg::RES_W-1:0] res,
    output logic coef_valid,
    output logic [luma_cost_pkg::N_COEF*luma_cost_pkg::COEF_W-1:0] coef
);
    import luma_cost_pkg::*;

    // Sign-extended residual samples
    logic signed [COEF_W-1:0] x [N_COEF];
    // One packed word of four outputs per row or column
    logic [4*COEF_W-1:0] row_d [4];
    logic [4*COEF_W-1:0] row_q [4];
    logic [4*COEF_W-1:0] col_d [4];
    logic                row_valid;

    // ------------------------------------------------------------------
    // 1-D butterfly with rows (1,1,1,1) (2,1,-1,-2) (1,-1,-1,1) (1,-2,2,-1)
    // ------------------------------------------------------------------
    function automatic logic [4*COEF_W-1:0] core_1d(
        input logic signed [COEF_W-1:0] x0,
        input logic signed [COEF_W-1:0] x1,
        input logic signed [COEF_W-1:0] x2,
        input logic signed [COEF_W-1:0] x3
    );
        logic signed [COEF_W-1:0] s03;
        logic signed [COEF_W-1:0] d03;
        logic signed [COEF_W-1:0] s12;
        logic signed [COEF_W-1:0] d12;
        s03 = x0 + x3;
        d03 = x0 - x3;
        s12 = x1 + x2;
        d12 = x1 - x2;
        // Output 0 at the low end
        return {d03 - (d12 <<< 1), s03 - s12, (d03 <<< 1) + d12, s03 + s12};
    endfunction

    // Row pass, Y[r][k] from X[r][0..3]
    always_comb begin
        for (int i = 0; i < N_COEF; i++) begin
            x[i] = COEF_W'($signed(res[i*RES_W +: RES_W]));
        end
        for (int r = 0; r < 4; r++) begin
            row_d[r] = core_1d(x[4*r], x[4*r+1], x[4*r+2], x[4*r+3]);
        end
    end

    // Column pass over the registered rows
    always_comb begin
        for (int c = 0; c < 4; c++) begin
            col_d[c] = core_1d(row_q[0][c*COEF_W +: COEF_W],
                               row_q[1][c*COEF_W +: COEF_W],
                               row_q[2][c*COEF_W +: COEF_W],
                               row_q[3][c*COEF_W +: COEF_W]);
        end
    end

    // ------------------------------------------------------------------
    // Two-deep valid pipe and payload registers
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_valid  <= 1'b0;
            coef_valid <= 1'b0;
        end else begin
            row_valid  <= res_valid;
            coef_valid <= row_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (res_valid) begin
            row_q <= row_d;
        end
        if (row_valid) begin
            // Column c, output k lands at index 4k+c
            for (int c = 0; c < 4; c++) begin
                for (int k = 0; k < 4; k++) begin
                    coef[(4*k+c)*COEF_W +: COEF_W] <= col_d[c][k*COEF_W +: COEF_W];
                end
            end
        end
    end

    // Downstream quantizer and energy stage rely on a clean valid
    a_coef_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(coef_valid)
    );

endmodule

`default_nettype wire

// ==== quantizer.sv ====
/*
 * Intra forward quantizer: level = sign(c) * ((|c|*MF + 2^qbits/3) >> qbits)
 * with MF chosen by qp%6 and the coefficient position class
 */
`timescale 1ns/100ps
`default_nettype none

module quantizer (
    input  logic clk,
    input  logic rst_n,
    input  logic coef_valid,
    input  logic [luma_cost_pkg::N_COEF*luma_cost_pkg::COEF_W-1:0] coef,
    input  logic [luma_cost_pkg::QP_W-1:0] qp,
    output logic lvl_valid,
    output logic [luma_cost_pkg::N_COEF*luma_cost_pkg::LEVEL_W-1:0] lvl
);
    import luma_cost_pkg::*;

    logic [QP_W-1:0]           qp_div;
    logic [2:0]                qp_mod;
    logic [4:0]                qbits;
    logic [31:0]               round_off;
    logic signed [COEF_W-1:0]  c_in [N_COEF];
    logic [COEF_W-1:0]         mag [N_COEF];
    logic [31:0]               scaled [N_COEF];
    logic [LEVEL_W-1:0]        q_mag [N_COEF];
    logic [LEVEL_W-1:0]        q_lvl [N_COEF];

    // Position class: 0 even/even, 1 odd/odd, 2 mixed
    function automatic logic [1:0] pos_class(input logic [3:0] idx);
        if (!idx[2] && !idx[0]) begin
            return 2'd0;
        end else if (idx[2] && idx[0]) begin
            return 2'd1;
        end
        return 2'd2;
    endfunction

    // ------------------------------------------------------------------
    // qp split and rounding offset
    // ------------------------------------------------------------------
    always_comb begin
        qp_div    = qp / 6'd6;
        qp_mod    = 3'(qp % 6'd6);
        qbits     = 5'(QBITS_BASE) + 5'(qp_div);
        round_off = (32'd1 << qbits) / 32'd3;
    end

    // Per-coefficient scale, round and shift
    always_comb begin
        for (int i = 0; i < N_COEF; i++) begin
            c_in[i]   = $signed(coef[i*COEF_W +: COEF_W]);
            mag[i]    = c_in[i][COEF_W-1] ? COEF_W'(-c_in[i]) : COEF_W'(c_in[i]);
            scaled[i] = 32'(mag[i]) * 32'(QUANT_MF[qp_mod][pos_class(4'(i))]);
            scaled[i] = (scaled[i] + round_off) >> qbits;
            q_mag[i]  = scaled[i][LEVEL_W-1:0];
            // Level takes the sign of its coefficient
            q_lvl[i]  = c_in[i][COEF_W-1] ? -q_mag[i] : q_mag[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lvl_valid <= 1'b0;
        end else begin
            lvl_valid <= coef_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (coef_valid) begin
            for (int i = 0; i < N_COEF; i++) begin
                lvl[i*LEVEL_W +: LEVEL_W] <= q_lvl[i];
            end
        end
    end

    // qp arrives from the register block, which clamps on write
    a_qp_range: assert property (
        @(posedge clk) disable iff (!rst_n) qp <= QP_MAX
    );

endmodule

`default_nettype wire

// ==== level_energy.sv ====
/*
 * Energy of a quantized block: registered sum of squared levels,
 * with the levels passed alongside
 */
`timescale 1ns/100ps
`default_nettype none

module level_energy (
    input  logic clk,
    input  logic rst_n,
    input  logic lvl_valid,
    input  logic [luma_cost_pkg::N_COEF*luma_cost_pkg::LEVEL_W-1:0] lvl,
    output logic out_valid,
    output logic [luma_cost_pkg::N_COEF*luma_cost_pkg::LEVEL_W-1:0] levels,
    output logic [luma_cost_pkg::COST_W-1:0] cost
);
    import luma_cost_pkg::*;

    logic signed [LEVEL_W-1:0]   lv [N_COEF];
    logic signed [2*LEVEL_W-1:0] sq [N_COEF];
    logic [COST_W-1:0]           sum;

    // Squares are non-negative, so the sum fits without sign handling
    always_comb begin
        sum = '0;
        for (int i = 0; i < N_COEF; i++) begin
            lv[i] = $signed(lvl[i*LEVEL_W +: LEVEL_W]);
            sq[i] = (2*LEVEL_W)'(lv[i]) * (2*LEVEL_W)'(lv[i]);
            sum   = sum + COST_W'(sq[i]);
        end
    end

    // Cost holds between blocks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            cost      <= '0;
        end else begin
            out_valid <= lvl_valid;
            if (lvl_valid) begin
                cost <= sum;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lvl_valid) begin
            levels <= lvl;
        end
    end

endmodule

`default_nettype wire

// ==== cost_regs_apb.sv ====
/*
 * APB slave: qp register with clamping, block count and total
 * energy accumulators, clear strobe and slave error decode
 */
`timescale 1ns/100ps
`default_nettype none

module cost_regs_apb (
    input  logic clk,
    input  logic rst_n,
    input  logic [luma_cost_pkg::PADDR_W-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [luma_cost_pkg::PDATA_W-1:0] pwdata,
    output logic [luma_cost_pkg::PDATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr,
    input  logic out_valid,
    input  logic [luma_cost_pkg::COST_W-1:0] cost,
    output logic [luma_cost_pkg::QP_W-1:0] qp
);
    import luma_cost_pkg::*;

    logic             access;
    logic             hit_qp;
    logic             hit_cnt;
    logic             hit_tot;
    logic             hit_clr;
    logic             qp_wr;
    logic             clr_wr;
    logic [CNT_W-1:0] blk_cnt;
    logic [CNT_W-1:0] cost_tot;

    // ------------------------------------------------------------------
    // Decode, access phase only
    // ------------------------------------------------------------------
    assign access  = psel && penable;
    assign hit_qp  = (paddr == ADDR_QP);
    assign hit_cnt = (paddr == ADDR_BLK_CNT);
    assign hit_tot = (paddr == ADDR_COST_TOT);
    assign hit_clr = (paddr == ADDR_CLEAR);
    assign qp_wr   = access && pwrite && hit_qp;
    assign clr_wr  = access && pwrite && hit_clr;

    // Zero wait states
    assign pready = 1'b1;

    // Unmapped address, or write to a read-only register
    assign pslverr = access && (!(hit_qp || hit_cnt || hit_tot || hit_clr)
                                || (pwrite && (hit_cnt || hit_tot)));

    // Read mux, clear address reads as zero
    always_comb begin
        case (paddr)
            ADDR_QP:       prdata = PDATA_W'(qp);
            ADDR_BLK_CNT:  prdata = PDATA_W'(blk_cnt);
            ADDR_COST_TOT: prdata = PDATA_W'(cost_tot);
            default:       prdata = '0;
        endcase
    end

    // ------------------------------------------------------------------
    // qp register and running totals
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qp <= QP_RESET;
        end else if (qp_wr) begin
            // Values above QP_MAX saturate
            qp <= (pwdata > PDATA_W'(QP_MAX)) ? QP_MAX : pwdata[QP_W-1:0];
        end
    end

    // Clear wins over a block finishing on the same edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk_cnt  <= '0;
            cost_tot <= '0;
        end else if (clr_wr) begin
            blk_cnt  <= '0;
            cost_tot <= '0;
        end else if (out_valid) begin
            blk_cnt  <= blk_cnt + 1'b1;
            // Wraps in 32 bits
            cost_tot <= cost_tot + CNT_W'(cost);
        end
    end

    // Access phase must follow a setup cycle with psel held and penable low
    a_apb_setup: assert property (
        @(posedge clk) disable iff (!rst_n) penable |-> psel && $past(psel && !penable)
    );

endmodule

`default_nettype wire

// ==== luma_cost_top.sv ====
/*
 * Luma 4x4 cost pipeline top: residual, transform, quantizer
 * and energy stages, plus the APB register block
 */
`timescale 1ns/100ps
`default_nettype none

module luma_cost_top (
    input  logic clk,
    input  logic rst_n,
    input  logic [luma_cost_pkg::N_COEF*luma_cost_pkg::PIX_W-1:0] orig,
    input  logic [luma_cost_pkg::N_COEF*luma_cost_pkg::PIX_W-1:0] pred,
    input  logic in_valid,
    output logic [luma_cost_pkg::N_COEF*luma_cost_pkg::LEVEL_W-1:0] levels,
    output logic [luma_cost_pkg::COST_W-1:0] cost,
    output logic out_valid,
    input  logic [luma_cost_pkg::PADDR_W-1:0] paddr,
    input  logic psel,
    input  logic penable,
    input  logic pwrite,
    input  logic [luma_cost_pkg::PDATA_W-1:0] pwdata,
    output logic [luma_cost_pkg::PDATA_W-1:0] prdata,
    output logic pready,
    output logic pslverr
);
    import luma_cost_pkg::*;

    // ------------------------------------------------------------------
    // Stage-to-stage links
    // ------------------------------------------------------------------
    logic                        res_valid;
    logic [N_COEF*RES_W-1:0]     res;
    logic                        coef_valid;
    logic [N_COEF*COEF_W-1:0]    coef;
    logic                        lvl_valid;
    logic [N_COEF*LEVEL_W-1:0]   lvl;
    logic [QP_W-1:0]             qp;

    // 1 cycle
    residual_stage u_residual (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .orig(orig), .pred(pred),
        .res_valid(res_valid), .res(res)
    );

    // 2 cycles
    fwd_transform_4x4 u_transform (
        .clk(clk), .rst_n(rst_n),
        .res_valid(res_valid), .res(res),
        .coef_valid(coef_valid), .coef(coef)
    );

    // 1 cycle, qp from the register block
    quantizer u_quant (
        .clk(clk), .rst_n(rst_n),
        .coef_valid(coef_valid), .coef(coef), .qp(qp),
        .lvl_valid(lvl_valid), .lvl(lvl)
    );

    // 1 cycle
    level_energy u_energy (
        .clk(clk), .rst_n(rst_n),
        .lvl_valid(lvl_valid), .lvl(lvl),
        .out_valid(out_valid), .levels(levels), .cost(cost)
    );

    // Totals follow out_valid by one cycle
    cost_regs_apb u_regs (
        .clk(clk), .rst_n(rst_n),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .out_valid(out_valid), .cost(cost), .qp(qp)
    );

endmodule

`default_nettype wire

// ==== tb_luma_cost.sv ====
/*
 * Testbench for the luma 4x4 cost pipeline: reference model,
 * expected-result queue, APB access tasks and directed tests
 */
`timescale 1ns/100ps
`default_nettype none

module tb_luma_cost;
    import luma_cost_pkg::*;

    localparam int LIMIT = 3000;

    logic         clk;
    logic         rst_n;
    logic [127:0] orig;
    logic [127:0] pred;
    logic         in_valid;
    logic [255:0] levels;
    logic [31:0]  cost;
    logic         out_valid;
    logic [3:0]   paddr;
    logic         psel;
    logic         penable;
    logic         pwrite;
    logic [31:0]  pwdata;
    logic [31:0]  prdata;
    logic         pready;
    logic         pslverr;

    int           cycle;
    int           errors;
    integer       seed;
    int           cur_qp;
    int           model_cnt;
    logic [31:0]  model_tot;
    string        test_name;

    // Expected results, oldest block at the front
    logic [255:0] exp_levels [$];
    logic [31:0]  exp_cost [$];
    int           exp_cycle [$];

    // Forward quantizer multipliers, three classes per qp%6 row
    int mf_tab [18] = '{13107, 5243, 8066, 11916, 4660, 7490, 10082, 4194, 6554,
                        9362, 3647, 5825, 8192, 3355, 5243, 7282, 2893, 4559};

    luma_cost_top DUT (
        .clk(clk), .rst_n(rst_n), .orig(orig), .pred(pred), .in_valid(in_valid),
        .levels(levels), .cost(cost), .out_valid(out_valid),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #2 clk = ~clk;

    // Cycle count and run limit
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle == LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [255:0] model_levels(input logic [127:0] o,
                                                  input logic [127:0] p, input int q);
        int          x [16];
        int          t [16];
        int          w [16];
        int          cm [4][4];
        int          r;
        int          c;
        int          cls;
        int          qbits;
        int          mag;
        longint      prod;
        logic [255:0] out;
        cm = '{'{1, 1, 1, 1}, '{2, 1, -1, -2}, '{1, -1, -1, 1}, '{1, -2, 2, -1}};
        for (int i = 0; i < 16; i++) begin
            x[i] = int'(o[i*8 +: 8]) - int'(p[i*8 +: 8]);
        end
        // T = C.X
        for (int i = 0; i < 4; i++) begin
            for (int l = 0; l < 4; l++) begin
                t[4*i+l] = 0;
                for (int k = 0; k < 4; k++) begin
                    t[4*i+l] += cm[i][k] * x[4*k+l];
                end
            end
        end
        // W = T.Ct
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 4; j++) begin
                w[4*i+j] = 0;
                for (int l = 0; l < 4; l++) begin
                    w[4*i+j] += t[4*i+l] * cm[j][l];
                end
            end
        end
        qbits = 15 + q / 6;
        for (int i = 0; i < 16; i++) begin
            r = i / 4;
            c = i % 4;
            if (r % 2 == 0 && c % 2 == 0) begin
                cls = 0;
            end else if (r % 2 == 1 && c % 2 == 1) begin
                cls = 1;
            end else begin
                cls = 2;
            end
            mag  = (w[i] < 0) ? -w[i] : w[i];
            prod = longint'(mag) * longint'(mf_tab[3*(q%6)+cls])
                 + ((longint'(1) << qbits) / 3);
            mag  = int'(prod >>> qbits);
            out[i*16 +: 16] = (w[i] < 0) ? 16'(-mag) : 16'(mag);
        end
        return out;
    endfunction

    function automatic logic [31:0] model_cost(input logic [255:0] lv);
        int s;
        int v;
        s = 0;
        for (int i = 0; i < 16; i++) begin
            v = int'($signed(lv[i*16 +: 16]));
            s += v * v;
        end
        return 32'(s);
    endfunction

    // ------------------------------------------------------------------
    // Checking and stimulus tasks
    // ------------------------------------------------------------------
    task automatic check(input string name, input logic [255:0] exp, input logic [255:0] act);
        if (exp !== act) begin
            errors++;
            $display("Fail %s: expected %0h, actual %0h", name, exp, act);
        end
    endtask

    // Outputs sampled on the falling edge, well clear of the update edge
    always @(negedge clk) begin
        if (rst_n && out_valid) begin
            if (exp_cost.size() == 0) begin
                errors++;
                $display("out_valid went high with no block in flight");
            end else begin
                check({test_name, " levels"}, exp_levels.pop_front(), levels);
                check({test_name, " cost"}, 256'(exp_cost.pop_front()), 256'(cost));
                check({test_name, " latency"}, 256'(5), 256'(cycle - exp_cycle.pop_front()));
            end
        end
    end

    // One block in, its expected levels queued
    task automatic drive_block(input logic [127:0] o, input logic [127:0] p,
                               input logic [255:0] lv);
        @(posedge clk);
        orig     <= o;
        pred     <= p;
        in_valid <= 1'b1;
        exp_levels.push_back(lv);
        exp_cost.push_back(model_cost(lv));
        // Counter value once this edge has settled
        exp_cycle.push_back(cycle + 1);
        model_cnt++;
        model_tot += model_cost(lv);
    endtask

    task automatic send_block(input logic [127:0] o, input logic [127:0] p);
        drive_block(o, p, model_levels(o, p, cur_qp));
    endtask

    // Stop feeding blocks and wait for every one in flight
    task automatic drain;
        @(posedge clk);
        in_valid <= 1'b0;
        while (exp_cost.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
    endtask

    task automatic apb_write(input logic [3:0] a, input logic [31:0] d, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= a;
        pwdata  <= d;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check({test_name, " pready"}, 256'(1), 256'(pready));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] a, output logic [31:0] d, output logic err);
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= a;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        d   = prdata;
        err = pslverr;
        check({test_name, " pready"}, 256'(1), 256'(pready));
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic set_qp(input int q);
        logic err;
        apb_write(ADDR_QP, 32'(q), err);
        cur_qp = q;
    endtask

    // ------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------
    task automatic test_reset;
        logic [31:0] d;
        logic        err;
        test_name = "test_reset";
        check(test_name, 256'(0), 256'(out_valid));
        check("test_reset cost", 256'(0), 256'(cost));
        apb_read(ADDR_QP, d, err);
        check("test_reset qp", 256'(26), 256'(d));
        apb_read(ADDR_BLK_CNT, d, err);
        check("test_reset blk_cnt", 256'(0), 256'(d));
        apb_read(ADDR_COST_TOT, d, err);
        check("test_reset cost_tot", 256'(0), 256'(d));
    endtask

    task automatic test_zero_residual;
        logic [127:0] blk;
        test_name = "test_zero_residual";
        blk = {$random(seed), $random(seed), $random(seed), $random(seed)};
        // No residual, so every level and the cost are zero
        drive_block(blk, blk, '0);
        drain();
    endtask

    task automatic test_directed_blocks;
        logic [127:0] o;
        logic [127:0] p;
        test_name = "test_directed_blocks";
        set_qp(26);
        // Flat offset
        o = {16{8'd100}};
        p = {16{8'd90}};
        send_block(o, p);
        // Horizontal ramp and checkerboard
        for (int i = 0; i < 16; i++) begin
            o[i*8 +: 8] = 8'((i % 4) * 40 + 20);
        end
        send_block(o, {16{8'd60}});
        for (int i = 0; i < 16; i++) begin
            o[i*8 +: 8] = ((i / 4 + i % 4) % 2 == 1) ? 8'd200 : 8'd30;
        end
        send_block(o, {16{8'd100}});
        drain();
    endtask

    task automatic test_random_stream;
        int qps [4];
        qps = '{0, 22, 37, 51};
        test_name = "test_random_stream";
        for (int g = 0; g < 4; g++) begin
            set_qp(qps[g]);
            for (int b = 0; b < 10; b++) begin
                send_block({$random(seed), $random(seed), $random(seed), $random(seed)},
                           {$random(seed), $random(seed), $random(seed), $random(seed)});
            end
            drain();
        end
    endtask

    task automatic test_apb_qp;
        logic [31:0] d;
        logic        err;
        test_name = "test_apb_qp";
        apb_write(ADDR_QP, 32'd60, err);
        check("test_apb_qp write err", 256'(0), 256'(err));
        apb_read(ADDR_QP, d, err);
        check("test_apb_qp clamp", 256'(51), 256'(d));
        apb_write(ADDR_BLK_CNT, 32'd5, err);
        check("test_apb_qp ro write", 256'(1), 256'(err));
        apb_read(4'h2, d, err);
        check("test_apb_qp unmapped", 256'(1), 256'(err));
        set_qp(26);
    endtask

    task automatic test_totals;
        logic [31:0] d;
        logic        err;
        test_name = "test_totals";
        apb_read(ADDR_BLK_CNT, d, err);
        check("test_totals blk_cnt", 256'(model_cnt), 256'(d));
        apb_read(ADDR_COST_TOT, d, err);
        check("test_totals cost_tot", 256'(model_tot), 256'(d));
        apb_write(ADDR_CLEAR, 32'd1, err);
        model_cnt = 0;
        model_tot = '0;
        apb_read(ADDR_BLK_CNT, d, err);
        check("test_totals cleared cnt", 256'(0), 256'(d));
        apb_read(ADDR_COST_TOT, d, err);
        check("test_totals cleared tot", 256'(0), 256'(d));
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        orig      = '0;
        pred      = '0;
        in_valid  = 1'b0;
        paddr     = '0;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        pwdata    = '0;
        cycle     = 0;
        errors    = 0;
        seed      = 14;
        cur_qp    = 26;
        model_cnt = 0;
        model_tot = '0;
        test_name = "setup";
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        test_reset();
        test_zero_residual();
        test_directed_blocks();
        test_random_stream();
        test_apb_qp();
        test_totals();
        repeat (2) @(posedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
luma_cost_pkg.sv
residual_stage.sv
fwd_transform_4x4.sv
quantizer.sv
level_energy.sv
cost_regs_apb.sv
luma_cost_top.sv
tb_luma_cost.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the luma cost testbench with Verilator

verilator --binary --timing --assert --top-module tb_luma_cost \
    -f all.f -o sim_tb > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Simulation exited with an error, see sim.log"; exit 1; }

grep -q "TEST FAIL" sim.log && { echo "Simulation reported failure"; exit 1; }
grep -q "TEST PASS" sim.log || { echo "No pass result in sim.log"; exit 1; }
echo "Simulation passed"
